/* hdl/dump_pkg.sv */
`default_nettype none

package dump_pkg;

   typedef logic [7:0]  byte_t;        // one data byte
   typedef logic [23:0] flash_addr_t;  // flash byte address

   localparam byte_t FLASH_READ_CMD = 8'h03;  // standard read, no dummy cycles
   localparam int DUMP_LEN = 256;             // bytes per dump

   // 1200 baud at 48 MHz
   localparam int DEFAULT_CLKS_PER_BIT = 40000;

   typedef enum logic [1:0] {
      seq_idle,
      seq_request,
      seq_wait_data,
      seq_wait_tx
   } seq_state_t;

   typedef enum logic [1:0] {
      spi_idle,
      spi_shift_out,
      spi_shift_in,
      spi_hold
   } spi_state_t;

endpackage

`default_nettype wire

/* hdl/spi_flash_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   rd_req,
   input  dump_pkg::flash_addr_t rd_addr,
   input  wire                   rd_ack,
   output logic                  data_valid,
   output dump_pkg::byte_t       rd_data,
   output logic                  spi_sck,
   output logic                  spi_ss,
   output logic                  spi_mosi,
   input  wire                   spi_miso
);

   import dump_pkg::*;

   spi_state_t  state;
   logic [4:0]  bit_cnt;
   logic [31:0] out_sr;   // command then address, msb first
   byte_t       in_sr;

   assign spi_mosi = out_sr[31];
   assign rd_data  = in_sr;

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= spi_idle;
         bit_cnt    <= '0;
         out_sr     <= '0;
         spi_sck    <= 1'b0;
         spi_ss     <= 1'b1;
         data_valid <= 1'b0;
      end else begin
         case (state)
            spi_idle: begin
               if (rd_req) begin
                  spi_ss  <= 1'b0;
                  spi_sck <= 1'b0;
                  out_sr  <= {FLASH_READ_CMD, rd_addr};  // first bit valid before rising edge
                  bit_cnt <= '0;
                  state   <= spi_shift_out;
               end
            end

            spi_shift_out: begin
               if (!spi_sck) begin
                  spi_sck <= 1'b1;             // flash samples here
               end else begin
                  spi_sck <= 1'b0;
                  out_sr  <= {out_sr[30:0], 1'b0};  // next bit on falling edge
                  if (bit_cnt == 5'd31) begin
                     bit_cnt <= '0;
                     state   <= spi_shift_in;
                  end else begin
                     bit_cnt <= bit_cnt + 5'd1;
                  end
               end
            end

            spi_shift_in: begin
               if (bit_cnt == 5'd8) begin
                  // one quiet cycle with sck low before releasing ss
                  spi_ss     <= 1'b1;
                  data_valid <= 1'b1;
                  state      <= spi_hold;
               end else if (!spi_sck) begin
                  spi_sck <= 1'b1;
                  in_sr   <= {in_sr[6:0], spi_miso};  // sample at rising edge
               end else begin
                  spi_sck <= 1'b0;
                  bit_cnt <= bit_cnt + 5'd1;
               end
            end

            spi_hold: begin
               if (rd_ack) begin
                  data_valid <= 1'b0;
                  state      <= spi_idle;
               end
            end

            default: begin
               state <= spi_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = dump_pkg::DEFAULT_CLKS_PER_BIT
) (
   input  wire             clk,
   input  wire             rst,
   input  wire             tx_start,
   input  dump_pkg::byte_t tx_data,
   output logic            tx_serial,
   output logic            tx_busy
);

   import dump_pkg::*;

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

   logic [CNT_W-1:0] clk_cnt;
   logic [3:0]       bit_cnt;
   logic [9:0]       frame;    // stop, data lsb first, start

   assign tx_serial = frame[0];

   always_ff @(posedge clk) begin
      if (rst) begin
         clk_cnt <= '0;
         bit_cnt <= '0;
         frame   <= '1;    // idle line high
         tx_busy <= 1'b0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            frame   <= {1'b1, tx_data, 1'b0};
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b1;
         end
      end else begin
         if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[9:1]};  // ones fill in behind the stop bit
            if (bit_cnt == 4'd9) begin
               tx_busy <= 1'b0;              // end of stop bit
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end else begin
            clk_cnt <= clk_cnt + CNT_W'(1);
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/dump_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   start,
   output logic                  rd_req,
   output dump_pkg::flash_addr_t rd_addr,
   output logic                  rd_ack,
   input  wire                   data_valid,
   input  dump_pkg::byte_t       rd_data,
   output logic                  tx_start,
   output dump_pkg::byte_t       tx_data,
   input  wire                   tx_busy,
   output logic                  busy,
   output logic                  done
);

   import dump_pkg::*;

   localparam flash_addr_t LAST_ADDR = flash_addr_t'(DUMP_LEN - 1);

   seq_state_t state;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= seq_idle;
         rd_addr  <= '0;
         rd_req   <= 1'b0;
         rd_ack   <= 1'b0;
         tx_start <= 1'b0;
         busy     <= 1'b0;
         done     <= 1'b0;
      end else begin
         rd_req   <= 1'b0;   // strobes last one cycle
         rd_ack   <= 1'b0;
         tx_start <= 1'b0;

         case (state)
            seq_idle: begin
               if (start) begin
                  rd_addr <= '0;
                  busy    <= 1'b1;
                  done    <= 1'b0;
                  state   <= seq_request;
               end
            end

            seq_request: begin
               // reader is back in idle by now, ack went out two cycles ago
               rd_req <= 1'b1;
               state  <= seq_wait_data;
            end

            seq_wait_data: begin
               if (data_valid && !tx_busy) begin
                  tx_data  <= rd_data;
                  tx_start <= 1'b1;
                  rd_ack   <= 1'b1;
                  rd_addr  <= rd_addr + flash_addr_t'(1);
                  if (rd_addr == LAST_ADDR) begin
                     state <= seq_wait_tx;
                  end else begin
                     state <= seq_request;  // overlap next read with this frame
                  end
               end
            end

            seq_wait_tx: begin
               // tx_busy only rises the cycle after tx_start
               if (!tx_busy && !tx_start) begin
                  busy  <= 1'b0;
                  done  <= 1'b1;
                  state <= seq_idle;
               end
            end

            default: begin
               state <= seq_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/flash_dump_top.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_dump_top #(
   parameter int CLKS_PER_BIT = dump_pkg::DEFAULT_CLKS_PER_BIT
) (
   input  wire  clk,
   input  wire  rst,
   input  wire  start,
   output logic spi_sck,
   output logic spi_ss,     // active low
   output logic spi_mosi,
   input  wire  spi_miso,
   output logic uart_tx,
   output logic busy,
   output logic done
);

   import dump_pkg::*;

   logic        rd_req;
   flash_addr_t rd_addr;
   logic        rd_ack;
   logic        data_valid;
   byte_t       rd_data;
   logic        tx_start;
   byte_t       tx_data;
   logic        tx_busy;

   dump_sequencer u_seq (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .rd_req     (rd_req),
      .rd_addr    (rd_addr),
      .rd_ack     (rd_ack),
      .data_valid (data_valid),
      .rd_data    (rd_data),
      .tx_start   (tx_start),
      .tx_data    (tx_data),
      .tx_busy    (tx_busy),
      .busy       (busy),
      .done       (done)
   );

   spi_flash_reader u_reader (
      .clk        (clk),
      .rst        (rst),
      .rd_req     (rd_req),
      .rd_addr    (rd_addr),
      .rd_ack     (rd_ack),
      .data_valid (data_valid),
      .rd_data    (rd_data),
      .spi_sck    (spi_sck),
      .spi_ss     (spi_ss),
      .spi_mosi   (spi_mosi),
      .spi_miso   (spi_miso)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_tx (
      .clk        (clk),
      .rst        (rst),
      .tx_start   (tx_start),
      .tx_data    (tx_data),
      .tx_serial  (uart_tx),
      .tx_busy    (tx_busy)
   );

endmodule

`default_nettype wire

/* testbench/flash_dump_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_dump_assert (
   input wire clk,
   input wire rst,
   input wire spi_sck,
   input wire spi_ss,
   input wire rd_req,
   input wire data_valid,
   input wire tx_start,
   input wire tx_busy,
   input wire busy,
   input wire done
);

   int fail_cnt = 0;

   sck_low_when_deselected: assert property (@(posedge clk) disable iff (rst)
      spi_ss |-> !spi_sck)
      else begin
         $error("spi_sck high while spi_ss is high");
         fail_cnt++;
      end

   no_req_while_valid: assert property (@(posedge clk) disable iff (rst)
      rd_req |-> !data_valid)
      else begin
         $error("rd_req while the reader still holds a byte");
         fail_cnt++;
      end

   tx_start_when_free: assert property (@(posedge clk) disable iff (rst)
      tx_start |-> !tx_busy)
      else begin
         $error("tx_start while the transmitter is busy");
         fail_cnt++;
      end

   busy_done_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(busy && done))
      else begin
         $error("busy and done high together");
         fail_cnt++;
      end

endmodule

bind flash_dump_top flash_dump_assert u_assert (
   .clk        (clk),
   .rst        (rst),
   .spi_sck    (spi_sck),
   .spi_ss     (spi_ss),
   .rd_req     (rd_req),
   .data_valid (data_valid),
   .tx_start   (tx_start),
   .tx_busy    (tx_busy),
   .busy       (busy),
   .done       (done)
);

`default_nettype wire

/* testbench/flash_dump_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_dump_tb;

   import dump_pkg::*;

   localparam int CLKS_PER_BIT   = 8;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES =
      RESET_CYCLES + 3 * DUMP_LEN * (10 * CLKS_PER_BIT + 90) + 2000;
   localparam logic [31:0] SEED  = 32'h946d_d320;

   logic clk = 1'b0;
   logic rst;
   logic start;
   logic spi_miso = 1'b0;
   wire  spi_sck;
   wire  spi_ss;
   wire  spi_mosi;
   wire  uart_tx;
   wire  busy;
   wire  done;

   byte_t       image [0:DUMP_LEN-1];
   byte_t       rx_q [$];        // bytes seen on the uart line
   byte_t       first_dump [$];
   logic        prev_sck = 1'b0;
   logic        prev_ss = 1'b1;
   logic        uart_prev = 1'b1;
   logic [31:0] cmd_sr = '0;     // command and address from mosi
   int          rise_cnt = 0;
   int          out_cnt = 0;
   int          exp_addr = 0;
   int          txn_cnt = 0;
   int          cycle_cnt = 0;
   int          i;

   always #4 clk = ~clk;

   flash_dump_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uut (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .uart_tx  (uart_tx),
      .busy     (busy),
      .done     (done)
   );

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic check_transaction();
      check_value("spi clock edges", 32'(rise_cnt), 32'd40);
      check_value("spi command", 32'(cmd_sr[31:24]), 32'(FLASH_READ_CMD));
      check_value("spi address", 32'(cmd_sr[23:0]), 32'(exp_addr));
      exp_addr++;
      txn_cnt++;
   endtask

   // flash model, looks at the spi pins half a cycle after they change
   always @(negedge clk) begin
      if (spi_ss) begin
         if (!prev_ss) begin
            check_transaction();
         end
         rise_cnt = 0;
         out_cnt  = 0;
      end else if (spi_sck && !prev_sck) begin
         if (rise_cnt < 32) begin
            cmd_sr = {cmd_sr[30:0], spi_mosi};
         end
         rise_cnt++;
      end else if (!spi_sck && prev_sck && rise_cnt >= 32 && out_cnt < 8) begin
         spi_miso = image[cmd_sr[7:0]][3'(7 - out_cnt)];  // msb first
         out_cnt++;
      end
      prev_sck = spi_sck;
      prev_ss  = spi_ss;
   end

   task automatic receive_frame();
      logic [9:0] bits;
      logic       first;
      int         b;
      int         k;
      for (b = 0; b < 10; b++) begin
         for (k = 0; k < CLKS_PER_BIT; k++) begin
            if (b != 0 || k != 0) begin
               @(negedge clk);
            end
            if (k == 0) begin
               first = uart_tx;
            end else begin
               check_value("uart bit steady for a bit time", 32'(uart_tx), 32'(first));
            end
            if (k == CLKS_PER_BIT / 2) begin
               bits[b] = uart_tx;  // mid-bit
            end
         end
         check_value("done during a frame", 32'(done), 32'd0);
         check_value("busy during a frame", 32'(busy), 32'd1);
      end
      check_value("uart start bit", 32'(bits[0]), 32'd0);
      check_value("uart stop bit", 32'(bits[9]), 32'd1);
      rx_q.push_back(bits[8:1]);
   endtask

   // uart decoder
   always @(negedge clk) begin
      if (!rst && uart_prev && !uart_tx) begin
         receive_frame();
      end
      uart_prev = uart_tx;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the run took more than %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $fatal(1, "run did not finish in time");
      end
   end

   task automatic run_dump(input bit stray_start);
      int delay;
      int n;
      exp_addr = 0;
      txn_cnt  = 0;
      rx_q.delete();
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_value("busy after start", 32'(busy), 32'd1);
      check_value("done after start", 32'(done), 32'd0);
      if (stray_start) begin
         delay = $urandom_range(20000, 200);  // lands inside the dump
         repeat (delay) @(negedge clk);
         check_value("busy before second start", 32'(busy), 32'd1);
         start = 1'b1;
         @(negedge clk);
         start = 1'b0;
      end
      while (!done) begin
         @(negedge clk);
      end
      check_value("busy with done high", 32'(busy), 32'd0);
      check_value("uart bytes received", 32'(rx_q.size()), 32'(DUMP_LEN));
      check_value("spi transactions", 32'(txn_cnt), 32'(DUMP_LEN));
      for (n = 0; n < DUMP_LEN; n++) begin
         check_value($sformatf("uart byte %0d", n), 32'(rx_q[n]), 32'(image[n]));
      end
   endtask

   initial begin
      void'($urandom(SEED));
      rst   = 1'b1;
      start = 1'b0;
      $readmemh("testbench/flash_dump_testdata.hex", image);
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_value("spi_ss after reset", 32'(spi_ss), 32'd1);
      check_value("spi_sck after reset", 32'(spi_sck), 32'd0);
      check_value("uart_tx after reset", 32'(uart_tx), 32'd1);
      check_value("busy after reset", 32'(busy), 32'd0);
      check_value("done after reset", 32'(done), 32'd0);

      run_dump(1'b1);
      first_dump = rx_q;
      repeat (50) @(negedge clk);
      check_value("done held until next start", 32'(done), 32'd1);

      run_dump(1'b0);
      for (i = 0; i < DUMP_LEN; i++) begin
         check_value($sformatf("second dump byte %0d", i), 32'(rx_q[i]),
                     32'(first_dump[i]));
      end

      if (uut.u_assert.fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         $display("%0d assertion failures", uut.u_assert.fail_cnt);
         $display("TESTBENCH FAILED");
         $fatal(1, "assertions failed");
      end
   end

endmodule

`default_nettype wire

/* project.f */
hdl/dump_pkg.sv
hdl/spi_flash_reader.sv
hdl/uart_tx.sv
hdl/dump_sequencer.sv
hdl/flash_dump_top.sv
testbench/flash_dump_assert.sv
testbench/flash_dump_tb.sv

/* Makefile */
# Verilator build and run for the flash dump engine

VERILATOR ?= verilator
TOP       ?= flash_dump_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/flash_dump_testdata.hex */
// flash image, one byte per entry, addresses 0x00 to 0xff in order
// 16 bytes per line, first entry of each line at address 16 * line
00 ff 5a a5 03 c3 3c 96 69 12 34 56 78 9a bc de
f0 0f e1 1e d2 2d c4 4c b7 7b a8 8a 99 11 22 33
44 55 66 77 88 aa bb cc dd ee 01 80 40 20 10 08
04 02 7f bf df ef f7 fb fd fe 13 57 9b df 24 68
ac e0 31 75 b9 fd 42 86 ca 0e 53 97 db 1f 64 a8
ec 30 71 b5 f9 3d 82 c6 0a 4e 93 d7 1b 5f a4 e8
2c 70 b1 f5 39 7d c2 06 4a 8e d3 17 5b 9f e4 28
6c b0 f1 35 79 bd 02 46 8a ce 13 57 9c e0 24 6d
de ad be ef ca fe ba be 0b ad f0 0d 5e ed 1a 7e
c0 ff ee 15 b0 a7 d0 0d 61 e5 9d 3a 27 84 f2 4b
e6 0c 73 a9 1d 58 cf 82 36 fa 4d 91 b4 08 e3 7a
2f d6 49 bc 05 98 63 ea 17 c8 5d 21 8f 3e f4 a0
72 0b d9 46 e7 1c 85 3b ce 60 97 f3 2a 5c b8 0e
d4 69 a3 fc 10 8b 47 e9 36 c5 7c 02 bf 58 9e 23
11 93 e5 6a 38 d1 4f 0a 87 bd 29 f6 c1 5b 74 ee
9a 03 6f d8 b2 45 1c e0 7d 26 a1 f9 53 c7 0f 5a
